// ==== bench/clip_testdata.txt ====
// scenario: map withhold_cycles writing_hold n_obj, then n_obj rows of addr x0 y0 x1 y1 color
// then n_exp, then n_exp expected rows of x0 y0 x1 y1 color (all hex, coords 16-bit two's complement)
4
// inside lines, prompt credits
80000089 0 0 4
00 000a 0014 0258 0190 05
03 0000 0000 027f 01df ff
07 0140 00f0 0064 0032 2a
1f 0005 01d6 0276 0009 13
4
000a 0014 0258 0190 5
0000 0000 027f 01df 7
0140 00f0 0064 0032 2
0005 01d6 0276 0009 3
// rejects and clipped lines, writing held for 20 cycles first
00000176 0 14 6
01 ffce 000a fffb 012c 11
02 0064 01f4 00c8 0258 22
04 0064 0064 02bc 0190 04
05 012c 00c8 0064 0258 07
06 ff9c ffce 02bc 0212 09
08 ff9c 0190 0064 02bc 0e
3
0064 0064 027f 0171 4
012c 00c8 00a1 01df 7
0000 0017 0275 01df 1
// six lines, credits withheld for 150 cycles
0000fc00 96 0 6
0a 0001 0002 0003 0004 01
0b 000b 000c 000d 000e 02
0c 0015 0016 0017 0018 03
0d ffec 0064 00c8 0064 0c
0e 0029 002a 002b 002c 05
0f 0033 0034 0035 0036 06
6
0001 0002 0003 0004 1
000b 000c 000d 000e 2
0015 0016 0017 0018 3
0000 0064 00c8 0064 4
0029 002a 002b 002c 5
0033 0034 0035 0036 6
// empty map
00000000 0 0 0
0

// ==== project.f ====
logic/clip_pkg.sv
logic/line_fifo.sv
logic/obj_scanner.sv
logic/clip_engine.sv
logic/raster_out.sv
logic/clipping_top.sv
bench/clip_clock.sv
bench/clipping_tb.sv

// ==== Makefile ====
TOP = clipping_tb

all: run

obj_dir/V$(TOP): project.f logic/*.sv bench/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f project.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "sim passed" sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -Wall \
		-f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// ==== bench/clipping_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module clipping_tb
    import clip_pkg::*;
();

    localparam int TD_WORDS       = 512;
    localparam int SCENARIO_LIMIT = 4000;  // cycles per scenario

    logic                 clk;
    logic                 rst_n;
    logic [OBJ_SLOTS-1:0] obj_map;
    line_t                obj;
    logic                 changed;
    logic                 writing;
    logic                 credit_return;
    logic [SLOT_W-1:0]    addr;
    logic                 read_en;
    logic                 start_refresh;
    logic                 reading;
    logic                 clr_changed;
    pix_line_t            line_out;
    logic                 vld;
    logic                 end_of_obj;

    logic [31:0] td [TD_WORDS];
    int          rp = 0;
    line_t       mem [OBJ_SLOTS];
    pix_line_t   exp_q [$];
    int          withhold_cycles = 0;
    int          n_scen = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          n_timeouts = 0;

    clip_clock clock_gen (.clk(clk));

    clipping_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .obj_map       (obj_map),
        .obj           (obj),
        .changed       (changed),
        .writing       (writing),
        .credit_return (credit_return),
        .addr          (addr),
        .read_en       (read_en),
        .start_refresh (start_refresh),
        .reading       (reading),
        .clr_changed   (clr_changed),
        .line_out      (line_out),
        .vld           (vld),
        .end_of_obj    (end_of_obj)
    );

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        n_checks++;
        assert (actual === expected) else begin
            n_errors++;
            $display("** Error at time %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        n_checks++;
        assert (cond) else begin
            n_errors++;
            $display("at time %0t: %s", $time, what);
        end
    endtask

    task automatic end_run();
        $display("checks: %0d, errors: %0d, timeouts: %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    endtask

    function automatic logic [31:0] take_word();
        logic [31:0] w;
        w  = td[rp];
        rp = rp + 1;
        return w;
    endfunction

    // five words: x0 y0 x1 y1 color
    function automatic line_t read_line();
        logic [31:0] w [5];
        line_t       ln;
        int          k;
        for (k = 0; k < 5; k++)
            w[k] = take_word();
        ln.x0    = w[0][15:0];
        ln.y0    = w[1][15:0];
        ln.x1    = w[2][15:0];
        ln.y1    = w[3][15:0];
        ln.color = w[4][7:0];
        return ln;
    endfunction

    function automatic line_t fill_line(input int slot);
        line_t ln;
        ln.x0    = 16'(slot);
        ln.y0    = 16'(slot * 3);
        ln.x1    = 16'(slot * 5);
        ln.y1    = 16'(slot * 7);
        ln.color = 8'(slot);
        return ln;
    endfunction

    task automatic check_reset_outputs();
        compare_value("start_refresh", 32'd0, 32'(start_refresh));
        compare_value("reading", 32'd0, 32'(reading));
        compare_value("read_en", 32'd0, 32'(read_en));
        compare_value("vld", 32'd0, 32'(vld));
        compare_value("end_of_obj", 32'd0, 32'(end_of_obj));
        compare_value("clr_changed", 32'd0, 32'(clr_changed));
    endtask

    task automatic run_scenario(input int idx);
        logic [31:0] map;
        int          wr_hold;
        int          nobj;
        int          nexp;
        int          slot;
        int          i;
        int          waited;
        line_t       ln;
        pix_line_t   px;
        map             = take_word();
        withhold_cycles = int'(take_word());
        wr_hold         = int'(take_word());
        nobj            = int'(take_word());
        for (i = 0; i < OBJ_SLOTS; i++)
            mem[i] = fill_line(i);
        for (i = 0; i < nobj; i++) begin
            slot      = int'(take_word());
            mem[slot] = read_line();
        end
        nexp = int'(take_word());
        exp_q.delete();
        for (i = 0; i < nexp; i++) begin
            ln       = read_line();
            px.x0    = ln.x0[9:0];  // rasterizer sees 10-bit coords
            px.y0    = ln.y0[9:0];
            px.x1    = ln.x1[9:0];
            px.y1    = ln.y1[9:0];
            px.color = ln.color[2:0];
            exp_q.push_back(px);
        end
        $display("scenario %0d: map 0x%08h, %0d lines expected", idx, map, nexp);

        obj_map = map;
        writing = (wr_hold > 0);
        changed = 1'b1;
        repeat (wr_hold) begin
            @(negedge clk);
            expect_true(!start_refresh && !reading, "refresh started while writing was high");
        end
        writing = 1'b0;

        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!start_refresh && waited < 16);
        expect_true(start_refresh, "changed did not start a refresh");
        @(negedge clk);
        compare_value("start_refresh", 32'd0, 32'(start_refresh));
        compare_value("reading", 32'd1, 32'(reading));

        waited = 0;
        while (!end_of_obj && waited < SCENARIO_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        expect_true(end_of_obj, "no end_of_obj at the end of the refresh");
        compare_value("reading", 32'd1, 32'(reading));
        changed = 1'b0;  // matrix unit drops it on clr_changed
        @(negedge clk);
        compare_value("end_of_obj", 32'd0, 32'(end_of_obj));
        compare_value("reading", 32'd0, 32'(reading));
        repeat (20) begin
            @(negedge clk);
            expect_true(!end_of_obj && !start_refresh, "extra end_of_obj or refresh after the end");
        end
        expect_true(exp_q.size() == 0, "some expected lines never appeared on line_out");
    endtask

    // object memory, data valid only in the cycle after read_en
    initial begin : obj_memory
        logic              pend;
        logic [SLOT_W-1:0] pend_addr;
        pend      = 1'b0;
        pend_addr = '0;
        obj       = '0;
        forever begin
            @(negedge clk);
            if (pend)
                obj = mem[pend_addr];
            else
                obj = 'x;
            pend      = read_en;
            pend_addr = addr;
        end
    end

    // rasterizer side, returns one credit per line taken
    initial begin : credit_driver
        int owed;
        int hold_left;
        int gap;
        void'($urandom(76454));
        owed          = 0;
        hold_left     = 0;
        gap           = 0;
        credit_return = 1'b0;
        forever begin
            @(negedge clk);
            if (start_refresh)
                hold_left = withhold_cycles;
            if (vld)
                owed++;
            if (credit_return)
                owed--;
            expect_true(owed <= RASTER_CREDITS, "vld sent without a credit left");
            credit_return = 1'b0;
            if (hold_left > 0) begin
                hold_left--;
            end else if (gap > 0) begin
                gap--;
            end else if (owed > 0) begin
                credit_return = 1'b1;
                gap           = int'($urandom % 4);
            end
        end
    end

    always @(negedge clk) begin : watch_outputs
        pix_line_t want;
        if (rst_n) begin
            compare_value("clr_changed", 32'(end_of_obj), 32'(clr_changed));
            if (vld) begin
                if (exp_q.size() == 0) begin
                    expect_true(1'b0, "line_out sent a line that was not expected");
                end else begin
                    want = exp_q.pop_front();
                    compare_value("line_out.x0", 32'(want.x0), 32'(line_out.x0));
                    compare_value("line_out.y0", 32'(want.y0), 32'(line_out.y0));
                    compare_value("line_out.x1", 32'(want.x1), 32'(line_out.x1));
                    compare_value("line_out.y1", 32'(want.y1), 32'(line_out.y1));
                    compare_value("line_out.color", 32'(want.color), 32'(line_out.color));
                end
            end
            if (end_of_obj)
                expect_true(exp_q.size() == 0, "end_of_obj came before all lines were sent");
        end
    end

    initial begin : watchdog
        @(posedge rst_n);
        repeat (n_scen * SCENARIO_LIMIT) @(posedge clk);
        n_timeouts++;
        $display("run timed out after %0d cycles", n_scen * SCENARIO_LIMIT);
        end_run();
    end

    initial begin : main_seq
        int s;
        rst_n   = 1'b0;
        obj_map = '0;
        changed = 1'b0;
        writing = 1'b0;
        $readmemh("bench/clip_testdata.txt", td);
        n_scen = int'(td[0]);
        rp     = 1;
        repeat (4) @(negedge clk);
        check_reset_outputs();
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        for (s = 0; s < n_scen; s++)
            run_scenario(s);
        end_run();
    end

endmodule

`default_nettype wire

// ==== bench/clip_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module clip_clock #(
    parameter int HALF_NS = 4
) (
    output logic clk = 1'b0
);

    always #(HALF_NS) clk = ~clk;  // 8 ns period

endmodule

`default_nettype wire

// ==== logic/clipping_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module clipping_top
    import clip_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [OBJ_SLOTS-1:0] obj_map,
    input  line_t                obj,
    input  logic                 changed,
    input  logic                 writing,
    input  logic                 credit_return,
    output logic [SLOT_W-1:0]    addr,
    output logic                 read_en,
    output logic                 start_refresh,
    output logic                 reading,
    output logic                 clr_changed,
    output pix_line_t            line_out,
    output logic                 vld,
    output logic                 end_of_obj
);

    logic            fifo_clear;
    logic            in_push;
    coded_line_t     in_push_data;
    logic            in_full;
    logic            in_empty;
    logic            in_rd;
    coded_line_t     in_head;
    logic            out_wr;
    pix_line_t       out_push_data;
    logic            out_full;
    logic            out_empty;
    logic            out_rd;
    pix_line_t       out_head;
    logic [SLOT_W:0] line_cnt;
    logic            scan_done;
    logic            refresh_done;
    logic            line_retired;

    obj_scanner scanner (
        .clk           (clk),
        .rst_n         (rst_n),
        .obj_map       (obj_map),
        .changed       (changed),
        .writing       (writing),
        .obj           (obj),
        .fifo_full     (in_full),
        .refresh_done  (refresh_done),
        .start_refresh (start_refresh),
        .reading       (reading),
        .addr          (addr),
        .read_en       (read_en),
        .push          (in_push),
        .push_data     (in_push_data),
        .fifo_clear    (fifo_clear),
        .line_cnt      (line_cnt),
        .scan_done     (scan_done)
    );

    line_fifo #(.WIDTH($bits(coded_line_t))) in_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (fifo_clear),
        .wr    (in_push),
        .wdata (in_push_data),
        .rd    (in_rd),
        .rdata (in_head),
        .empty (in_empty),
        .full  (in_full)
    );

    clip_engine engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_data      (in_head),
        .in_empty     (in_empty),
        .out_full     (out_full),
        .in_rd        (in_rd),
        .out_wr       (out_wr),
        .out_data     (out_push_data),
        .line_retired (line_retired)
    );

    line_fifo #(.WIDTH($bits(pix_line_t))) out_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (fifo_clear),
        .wr    (out_wr),
        .wdata (out_push_data),
        .rd    (out_rd),
        .rdata (out_head),
        .empty (out_empty),
        .full  (out_full)
    );

    raster_out out_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_refresh (start_refresh),
        .fifo_data     (out_head),
        .fifo_empty    (out_empty),
        .credit_return (credit_return),
        .line_retired  (line_retired),
        .line_cnt      (line_cnt),
        .scan_done     (scan_done),
        .fifo_rd       (out_rd),
        .line_out      (line_out),
        .vld           (vld),
        .end_of_obj    (end_of_obj),
        .clr_changed   (clr_changed),
        .refresh_done  (refresh_done)
    );

endmodule

`default_nettype wire

// ==== logic/raster_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_out
    import clip_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start_refresh,
    input  pix_line_t       fifo_data,
    input  logic            fifo_empty,
    input  logic            credit_return,
    input  logic            line_retired,
    input  logic [SLOT_W:0] line_cnt,
    input  logic            scan_done,
    output logic            fifo_rd,
    output pix_line_t       line_out,
    output logic            vld,
    output logic            end_of_obj,
    output logic            clr_changed,
    output logic            refresh_done
);

    logic [CREDIT_W-1:0] credits;
    logic [SLOT_W:0]     retired;
    logic                end_pulse;
    logic                end_cond;

    assign fifo_rd = (credits != '0) && !fifo_empty;

    // everything scanned is retired and drained
    assign end_cond = scan_done && (retired == line_cnt) && fifo_empty && !vld && !end_pulse;

    assign end_of_obj   = end_pulse;
    assign clr_changed  = end_pulse;
    assign refresh_done = end_pulse;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CREDIT_W'(RASTER_CREDITS);
        end else if (fifo_rd && !credit_return) begin
            credits <= credits - 1'b1;
        end else if (credit_return && !fifo_rd) begin
            credits <= credits + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld       <= 1'b0;
            retired   <= '0;
            end_pulse <= 1'b0;
        end else begin
            vld       <= fifo_rd;
            end_pulse <= end_cond;
            if (start_refresh)
                retired <= '0;
            else if (line_retired)
                retired <= retired + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rd)
            line_out <= fifo_data;  // valid with vld
    end

endmodule

`default_nettype wire

// ==== logic/clip_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module clip_engine
    import clip_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  coded_line_t in_data,
    input  logic        in_empty,
    input  logic        out_full,
    output logic        in_rd,
    output logic        out_wr,
    output pix_line_t   out_data,
    output logic        line_retired
);

    clip_state_e        state;
    line_t              ln;
    logic [3:0]         oc0;
    logic [3:0]         oc1;
    logic               sel;       // 1 moves p1
    logic               y_edge;    // top/bottom edge, x is solved
    logic signed [15:0] edge_val;
    logic               neg;
    logic [31:0]        quo;
    logic [31:0]        rem;
    logic [31:0]        dmag;
    logic [4:0]         cnt;

    logic               accept;
    logic               reject;
    logic [3:0]         oc_sel;
    logic               e_is_y;
    logic signed [15:0] e_val;
    logic signed [16:0] d_main;
    logic signed [16:0] d_edge;
    logic signed [16:0] d_den;
    logic signed [33:0] prod;
    logic [32:0]        rem_shift;
    logic [33:0]        rem_diff;
    logic signed [31:0] q;
    logic signed [15:0] q_lo;
    logic signed [15:0] new_x;
    logic signed [15:0] new_y;

    assign accept = ((oc0 | oc1) == 4'b0);
    assign reject = ((oc0 & oc1) != 4'b0);

    // first crossed edge of the outside endpoint, top first
    always_comb begin
        oc_sel = sel ? oc1 : oc0;
        e_is_y = oc_sel[OC_TOP] || oc_sel[OC_BOTTOM];
        if (oc_sel[OC_TOP])
            e_val = 16'(YMAX);
        else if (oc_sel[OC_BOTTOM])
            e_val = '0;
        else if (oc_sel[OC_RIGHT])
            e_val = 16'(XMAX);
        else
            e_val = '0;

        if (e_is_y) begin
            d_main = ln.x1 - ln.x0;
            d_edge = e_val - ln.y0;
            d_den  = ln.y1 - ln.y0;
        end else begin
            d_main = ln.y1 - ln.y0;
            d_edge = e_val - ln.x0;
            d_den  = ln.x1 - ln.x0;
        end
        prod = d_main * d_edge;  // magnitude stays below 2^32
    end

    // restoring divider step
    assign rem_shift = {rem, quo[31]};
    assign rem_diff  = {1'b0, rem_shift} - {2'b00, dmag};

    assign q     = neg ? -$signed(quo) : $signed(quo);  // truncates toward zero
    assign q_lo  = q[15:0];
    assign new_x = y_edge ? ln.x0 + q_lo : edge_val;
    assign new_y = y_edge ? edge_val : ln.y0 + q_lo;

    assign in_rd        = (state == c_load);
    assign out_wr       = (state == c_store) && !out_full;
    assign line_retired = out_wr || ((state == c_classify) && reject);

    always_comb begin
        out_data.x0    = ln.x0[9:0];
        out_data.y0    = ln.y0[9:0];
        out_data.x1    = ln.x1[9:0];
        out_data.y1    = ln.y1[9:0];
        out_data.color = ln.color[2:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= c_idle;
        end else begin
            case (state)
                c_idle: begin
                    if (!in_empty)
                        state <= c_load;
                end
                c_load: state <= c_classify;
                c_classify: begin
                    if (accept)
                        state <= c_store;
                    else if (reject)
                        state <= c_idle;
                    else
                        state <= c_setup;
                end
                c_setup: state <= c_divide;
                c_divide: begin
                    if (cnt == 5'd31)
                        state <= c_apply;
                end
                c_apply: state <= c_classify;
                c_store: begin
                    if (!out_full)
                        state <= c_idle;
                end
                default: state <= c_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            c_load: begin
                ln  <= in_data.ln;
                oc0 <= in_data.oc0;
                oc1 <= in_data.oc1;
            end
            c_classify: sel <= (oc0 == 4'b0);
            c_setup: begin
                y_edge   <= e_is_y;
                edge_val <= e_val;
                neg      <= prod[33] ^ d_den[16];
                quo      <= prod[33] ? 32'(-prod) : prod[31:0];
                dmag     <= d_den[16] ? 32'(-d_den) : 32'(d_den);
                rem      <= '0;
                cnt      <= '0;
            end
            c_divide: begin
                cnt <= cnt + 1'b1;
                quo <= {quo[30:0], !rem_diff[33]};
                if (!rem_diff[33])
                    rem <= rem_diff[31:0];
                else
                    rem <= rem_shift[31:0];  // restore
            end
            c_apply: begin
                if (sel) begin
                    ln.x1 <= new_x;
                    ln.y1 <= new_y;
                    oc1   <= outcode(new_x, new_y);
                end else begin
                    ln.x0 <= new_x;
                    ln.y0 <= new_y;
                    oc0   <= outcode(new_x, new_y);
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/obj_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module obj_scanner
    import clip_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [OBJ_SLOTS-1:0] obj_map,
    input  logic                 changed,
    input  logic                 writing,
    input  line_t                obj,
    input  logic                 fifo_full,
    input  logic                 refresh_done,
    output logic                 start_refresh,
    output logic                 reading,
    output logic [SLOT_W-1:0]    addr,
    output logic                 read_en,
    output logic                 push,
    output coded_line_t          push_data,
    output logic                 fifo_clear,
    output logic [SLOT_W:0]      line_cnt,
    output logic                 scan_done
);

    scan_state_e          state;
    logic [OBJ_SLOTS-1:0] map;
    logic [SLOT_W-1:0]    slot;
    logic                 last_slot;

    assign last_slot  = (slot == SLOT_W'(OBJ_SLOTS - 1));
    assign addr       = slot;
    assign fifo_clear = start_refresh;  // both queues start empty
    assign scan_done  = (state == s_done);
    assign push       = (state == s_push);  // obj valid here

    always_comb begin
        push_data.ln  = obj;
        push_data.oc0 = outcode(obj.x0, obj.y0);
        push_data.oc1 = outcode(obj.x1, obj.y1);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= s_idle;
            start_refresh <= 1'b0;
            reading       <= 1'b0;
            read_en       <= 1'b0;
            map           <= '0;
            slot          <= '0;
            line_cnt      <= '0;
        end else begin
            start_refresh <= 1'b0;
            read_en       <= 1'b0;

            if (start_refresh)
                reading <= 1'b1;
            else if (refresh_done)
                reading <= 1'b0;

            case (state)
                s_idle: begin
                    if (changed && !writing) begin
                        start_refresh <= 1'b1;
                        map           <= obj_map;
                        slot          <= '0;
                        line_cnt      <= '0;
                        state         <= s_issue;
                    end
                end
                s_issue: begin
                    if (!map[slot]) begin  // empty slot, skip
                        if (last_slot)
                            state <= s_done;
                        else
                            slot <= slot + 1'b1;
                    end else if (!fifo_full) begin
                        read_en <= 1'b1;
                        state   <= s_wait_data;
                    end
                end
                s_wait_data: state <= s_push;
                s_push: begin
                    line_cnt <= line_cnt + 1'b1;
                    if (last_slot) begin
                        state <= s_done;
                    end else begin
                        slot  <= slot + 1'b1;
                        state <= s_issue;
                    end
                end
                s_done: begin
                    if (refresh_done)
                        state <= s_idle;
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/line_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_fifo
    import clip_pkg::*;
#(
    parameter int WIDTH = 80
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clear,
    input  logic             wr,
    input  logic [WIDTH-1:0] wdata,
    input  logic             rd,
    output logic [WIDTH-1:0] rdata,
    output logic             empty,
    output logic             full
);

    logic [WIDTH-1:0]   mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW:0]   count;
    logic               do_wr;
    logic               do_rd;

    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;
    assign empty = (count == '0);
    assign full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign rdata = mem[rd_ptr];  // show-ahead head

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/clip_pkg.sv ====
`default_nettype none

package clip_pkg;

    // inclusive window, lower bounds are zero
    localparam int XMAX = 639;
    localparam int YMAX = 479;

    localparam int OC_LEFT   = 0;
    localparam int OC_RIGHT  = 1;
    localparam int OC_BOTTOM = 2;  // y < 0
    localparam int OC_TOP    = 3;  // y > YMAX

    localparam int FIFO_DEPTH     = 8;
    localparam int FIFO_AW        = $clog2(FIFO_DEPTH);
    localparam int RASTER_CREDITS = 4;
    localparam int CREDIT_W       = $clog2(RASTER_CREDITS + 1);
    localparam int OBJ_SLOTS      = 32;
    localparam int SLOT_W         = $clog2(OBJ_SLOTS);

    // object memory word, x0 in the low bits
    typedef struct packed {
        logic [7:0]         color;
        logic signed [15:0] y1;
        logic signed [15:0] x1;
        logic signed [15:0] y0;
        logic signed [15:0] x0;
    } line_t;

    typedef struct packed {
        logic [3:0] oc1;
        logic [3:0] oc0;
        line_t      ln;
    } coded_line_t;

    typedef struct packed {
        logic [2:0] color;
        logic [9:0] y1;
        logic [9:0] x1;
        logic [9:0] y0;
        logic [9:0] x0;
    } pix_line_t;

    typedef enum logic [2:0] {
        s_idle,
        s_issue,
        s_wait_data,
        s_push,
        s_done
    } scan_state_e;

    typedef enum logic [2:0] {
        c_idle,
        c_load,
        c_classify,
        c_setup,
        c_divide,
        c_apply,
        c_store
    } clip_state_e;

    function automatic logic [3:0] outcode(input logic signed [15:0] x,
                                           input logic signed [15:0] y);
        logic [3:0] oc;
        oc            = 4'b0;
        oc[OC_LEFT]   = (x < 0);
        oc[OC_RIGHT]  = (x > XMAX);
        oc[OC_BOTTOM] = (y < 0);
        oc[OC_TOP]    = (y > YMAX);
        return oc;
    endfunction

endpackage

`default_nettype wire
